/* Makefile */
# Verilator build of the execute stage testbench

obj_dir/Vexu_tb: exu.f source/exu_params.svh source/exu_pkg.sv source/alu.sv \
		source/next_pc.sv source/lsu.sv source/mem_arbiter.sv source/data_ram.sv \
		source/exu_top.sv testbench/exu_tb.sv
	verilator --binary --timing --top-module exu_tb -f exu.f

run: obj_dir/Vexu_tb
	./obj_dir/Vexu_tb > sim.log 2>&1; cat sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* exu.f */
+incdir+source
source/exu_pkg.sv
source/alu.sv
source/next_pc.sv
source/lsu.sv
source/mem_arbiter.sv
source/data_ram.sv
source/exu_top.sv
testbench/exu_tb.sv

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  exu_pkg::alu_op_e  alu_op,
    input  exu_pkg::alu_src_e alu_src,
    input  logic              cmp_negate,
    input  exu_pkg::word_t    rs1_d,
    input  exu_pkg::word_t    rs2_d,
    input  exu_pkg::word_t    imm,
    input  exu_pkg::word_t    pc,
    output exu_pkg::word_t    res
);
    import exu_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic [4:0] shamt;

    always_comb begin
        case (alu_src)
            SRC_RS1_RS2: begin
                op_a = rs1_d;
                op_b = rs2_d;
            end
            SRC_RS1_IMM: begin
                op_a = rs1_d;
                op_b = imm;
            end
            SRC_PC_IMM: begin
                op_a = pc;
                op_b = imm;
            end
            default: begin                        // lui form
                op_a = '0;
                op_b = imm;
            end
        endcase
    end

    assign eq    = (op_a == op_b);
    assign lt_s  = ($signed(op_a) < $signed(op_b));
    assign lt_u  = (op_a < op_b);
    assign shamt = op_b[4:0];

    // SUB is the equality compare; a plain subtract comes in as ADD with rs2 negated
    always_comb begin
        case (alu_op)
            ADD:     res = op_a + op_b;
            SUB:     res = {31'b0, eq ^ cmp_negate};     // beq / bne
            SLL:     res = op_a << shamt;
            SLT:     res = {31'b0, lt_s ^ cmp_negate};   // negate gives bge
            SLTU:    res = {31'b0, lt_u ^ cmp_negate};
            XOR:     res = op_a ^ op_b;
            SRL:     res = op_a >> shamt;
            SRA:     res = $signed(op_a) >>> shamt;
            OR:      res = op_a | op_b;
            AND:     res = op_a & op_b;
            default: res = '0;
        endcase
    end

    always_comb begin
        a_legal_op: assert (alu_op inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND})
            else $error("alu: illegal alu_op %0d", alu_op);
    end

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module data_ram (
    input  logic                   clk,
    input  logic                   ram_en,
    input  logic                   ram_we,
    input  logic [`EXU_MEM_AW-1:0] ram_addr,
    input  exu_pkg::word_t         ram_wdata,
    input  logic [3:0]             ram_wmask,
    output exu_pkg::word_t         ram_rdata
);
    import exu_pkg::*;

    word_t mem [0:`EXU_MEM_WORDS-1];

    initial begin
        for (int i = 0; i < `EXU_MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_en && ram_we) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_wmask[b]) begin
                    mem[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];   // one byte lane
                end
            end
        end
    end

    // registered read, holds its value across writes
    always_ff @(posedge clk) begin
        if (ram_en && !ram_we) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

/* source/exu_params.svh */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data path width
`define EXU_XLEN 32

// data RAM geometry, in 32-bit words
`define EXU_MEM_WORDS 256
`define EXU_MEM_AW 8

// exit code reported by ebreak when rs1 is not taken
`define EXU_EBREAK_CODE 9

`endif

/* source/exu_pkg.sv */
`include "exu_params.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] word_t;         // data and byte addresses

    // decoded operation kind
    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_EBREAK
    } op_class_e;

    // compares reuse SUB, SLT and SLTU with cmp_negate
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_RS1_RS2,
        SRC_RS1_IMM,
        SRC_PC_IMM,                               // auipc, jal target
        SRC_ZERO_IMM                              // lui
    } alu_src_e;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

endpackage

/* source/exu_top.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 op_valid,
    input  exu_pkg::op_class_e   op_class,
    input  exu_pkg::alu_op_e     alu_op,
    input  exu_pkg::alu_src_e    alu_src,
    input  exu_pkg::mem_size_e   mem_size,
    input  logic                 mem_signed,
    input  logic                 cmp_negate,
    input  logic                 use_rs1_code,
    input  exu_pkg::word_t       rs1_d,
    input  exu_pkg::word_t       rs2_d,
    input  exu_pkg::word_t       imm,
    input  exu_pkg::word_t       pc,
    output exu_pkg::word_t       rd_d,
    output exu_pkg::word_t       dnpc,
    output exu_pkg::word_t       csrw,
    output logic                 done,
    output logic                 halted,
    output exu_pkg::word_t       halt_code,
    input  logic                 host_req,
    input  logic                 host_we,
    input  exu_pkg::word_t       host_addr,   // byte address
    input  exu_pkg::word_t       host_wdata,
    output exu_pkg::word_t       host_rdata,
    output logic                 host_ack
);
    import exu_pkg::*;

    word_t res;
    word_t dnpc_next;
    word_t load_data;
    word_t ram_rdata;
    word_t lsu_wdata;
    word_t ram_wdata;
    word_t host_wdata_q;
    logic  is_mem;
    logic  is_jump;
    logic  lsu_start;
    logic  lsu_done;
    logic  lsu_req;
    logic  lsu_we;
    logic  lsu_gnt;
    logic  host_gnt;
    logic  [3:0] lsu_wmask;
    logic  [3:0] ram_wmask;
    logic  [`EXU_MEM_AW-1:0] lsu_addr;
    logic  [`EXU_MEM_AW-1:0] ram_addr;
    logic  [`EXU_MEM_AW-1:0] host_addr_q;
    logic  ram_en;
    logic  ram_we;
    logic  busy;                                  // memory operation in flight
    logic  mem_load_q;
    logic  host_pend;
    logic  host_we_q;

    assign is_mem    = (op_class == OP_LOAD) || (op_class == OP_STORE);
    assign is_jump   = (op_class == OP_JAL) || (op_class == OP_JALR);
    assign lsu_start = op_valid && is_mem && !busy;

    alu u_alu (
        .alu_op     (alu_op),
        .alu_src    (alu_src),
        .cmp_negate (cmp_negate),
        .rs1_d      (rs1_d),
        .rs2_d      (rs2_d),
        .imm        (imm),
        .pc         (pc),
        .res        (res)
    );

    next_pc u_next_pc (
        .op_class  (op_class),
        .pc        (pc),
        .rs1_d     (rs1_d),
        .imm       (imm),
        .taken     (res[0]),
        .dnpc_next (dnpc_next)
    );

    lsu u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (lsu_start),
        .write      (op_class == OP_STORE),
        .mem_signed (mem_signed),
        .mem_size   (mem_size),
        .addr       (res),
        .store_data (rs2_d),
        .gnt        (lsu_gnt),
        .rdata      (ram_rdata),
        .req        (lsu_req),
        .we         (lsu_we),
        .word_addr  (lsu_addr),
        .wdata      (lsu_wdata),
        .wmask      (lsu_wmask),
        .done       (lsu_done),
        .load_data  (load_data)
    );

    mem_arbiter u_mem_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .lsu_req         (lsu_req),
        .lsu_we          (lsu_we),
        .lsu_addr        (lsu_addr),
        .lsu_wdata       (lsu_wdata),
        .lsu_wmask       (lsu_wmask),
        .host_req        (host_pend),
        .host_we         (host_we_q),
        .host_addr       (host_addr_q),
        .host_wdata      (host_wdata_q),
        .lsu_gnt         (lsu_gnt),
        .host_gnt        (host_gnt),
        .ram_en          (ram_en),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_wmask       (ram_wmask),
        .host_data_valid (host_ack)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_wmask (ram_wmask),
        .ram_rdata (ram_rdata)
    );

    assign host_rdata = ram_rdata;               // valid together with host_ack

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done      <= 1'b0;
            busy      <= 1'b0;
            halted    <= 1'b0;
            host_pend <= 1'b0;
        end else begin
            done <= (op_valid && !is_mem) || lsu_done;
            if (lsu_start) begin
                busy <= 1'b1;
            end else if (lsu_done) begin
                busy <= 1'b0;
            end
            if (op_valid && op_class == OP_EBREAK) begin
                halted <= 1'b1;                   // sticky until reset
            end
            if (host_req) begin
                host_pend <= 1'b1;
            end else if (host_gnt) begin
                host_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            dnpc <= dnpc_next;
            csrw <= rs2_d;
            if (is_mem) begin
                mem_load_q <= (op_class == OP_LOAD);
            end else begin
                rd_d <= is_jump ? pc + 32'd4 : res;   // link address for jumps
            end
            if (op_class == OP_EBREAK) begin
                halt_code <= use_rs1_code ? rs1_d : word_t'(`EXU_EBREAK_CODE);
            end
        end
        if (lsu_done) begin
            rd_d <= mem_load_q ? load_data : '0;
        end
        if (host_req) begin
            host_we_q    <= host_we;
            host_addr_q  <= host_addr[`EXU_MEM_AW+1:2];
            host_wdata_q <= host_wdata;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> !busy)
        else $error("exu_top: op_valid while a memory operation is busy");

endmodule

/* source/lsu.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module lsu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   write,
    input  logic                   mem_signed,
    input  exu_pkg::mem_size_e     mem_size,
    input  exu_pkg::word_t         addr,
    input  exu_pkg::word_t         store_data,
    input  logic                   gnt,
    input  exu_pkg::word_t         rdata,
    output logic                   req,
    output logic                   we,
    output logic [`EXU_MEM_AW-1:0] word_addr,
    output exu_pkg::word_t         wdata,
    output logic [3:0]             wmask,
    output logic                   done,
    output exu_pkg::word_t         load_data
);
    import exu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,                                    // waiting for grant
        S_DATA                                    // RAM answers this cycle
    } state_e;

    state_e    state;
    word_t     addr_q;
    word_t     data_q;
    mem_size_e size_q;
    logic      signed_q;
    logic      write_q;
    logic [4:0] lane_shift;
    word_t     shifted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (gnt) begin
                        state <= S_DATA;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // operation fields are held for the whole access
    always_ff @(posedge clk) begin
        if (start && state == S_IDLE) begin
            addr_q   <= addr;
            data_q   <= store_data;
            size_q   <= mem_size;
            signed_q <= mem_signed;
            write_q  <= write;
        end
    end

    assign lane_shift = {addr_q[1:0], 3'b000};

    assign req       = (state == S_REQ);
    assign we        = write_q;
    assign word_addr = addr_q[`EXU_MEM_AW+1:2];
    assign wdata     = data_q << lane_shift;      // move rs2 into its byte lane
    assign done      = (state == S_DATA);

    always_comb begin
        case (size_q)
            MEM_BYTE: wmask = 4'b0001 << addr_q[1:0];
            MEM_HALF: wmask = addr_q[1] ? 4'b1100 : 4'b0011;
            default:  wmask = 4'b1111;
        endcase
    end

    assign shifted = rdata >> lane_shift;

    always_comb begin
        case (size_q)
            MEM_BYTE: load_data = {{24{shifted[7] & signed_q}}, shifted[7:0]};
            MEM_HALF: load_data = {{16{shifted[15] & signed_q}}, shifted[15:0]};
            default:  load_data = shifted;
        endcase
    end

    // a grant only answers an outstanding request
    a_gnt_on_req: assert property (@(posedge clk) disable iff (!rst_n)
        gnt |-> req)
        else $error("lsu: grant without a request");

    // the address comes straight from the alu sum
    a_half_align: assert property (@(posedge clk) disable iff (!rst_n)
        start && mem_size == MEM_HALF |-> !addr[0])
        else $error("lsu: misaligned halfword access at %h", addr);

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lsu_req,
    input  logic                   lsu_we,
    input  logic [`EXU_MEM_AW-1:0] lsu_addr,
    input  exu_pkg::word_t         lsu_wdata,
    input  logic [3:0]             lsu_wmask,
    input  logic                   host_req,
    input  logic                   host_we,
    input  logic [`EXU_MEM_AW-1:0] host_addr,
    input  exu_pkg::word_t         host_wdata,
    output logic                   lsu_gnt,
    output logic                   host_gnt,
    output logic                   ram_en,
    output logic                   ram_we,
    output logic [`EXU_MEM_AW-1:0] ram_addr,
    output exu_pkg::word_t         ram_wdata,
    output logic [3:0]             ram_wmask,
    output logic                   host_data_valid
);
    import exu_pkg::*;

    // lsu always wins, the host waits
    assign lsu_gnt  = lsu_req;
    assign host_gnt = host_req && !lsu_req;

    assign ram_en = lsu_gnt || host_gnt;

    always_comb begin
        if (lsu_gnt) begin
            ram_we    = lsu_we;
            ram_addr  = lsu_addr;
            ram_wdata = lsu_wdata;
            ram_wmask = lsu_wmask;
        end else begin
            ram_we    = host_gnt && host_we;
            ram_addr  = host_addr;
            ram_wdata = host_wdata;
            ram_wmask = 4'b1111;                  // host writes whole words
        end
    end

    // read data shows up one cycle after the access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_data_valid <= 1'b0;
        end else begin
            host_data_valid <= host_gnt;
        end
    end

    // a waiting host keeps its request up
    a_host_hold: assert property (@(posedge clk) disable iff (!rst_n)
        host_req && !host_gnt |=> host_req)
        else $error("mem_arbiter: host req dropped before grant");

endmodule

/* source/next_pc.sv */
`timescale 1ns/1ps

module next_pc (
    input  exu_pkg::op_class_e op_class,
    input  exu_pkg::word_t     pc,
    input  exu_pkg::word_t     rs1_d,
    input  exu_pkg::word_t     imm,
    input  logic               taken,
    output exu_pkg::word_t     dnpc_next
);
    import exu_pkg::*;

    word_t snpc;                                  // sequential pc
    word_t pc_rel;                                // jal and branch target
    word_t reg_rel;                               // jalr target before clearing bit 0

    assign snpc    = pc + 32'd4;
    assign pc_rel  = pc + imm;
    assign reg_rel = rs1_d + imm;

    always_comb begin
        case (op_class)
            OP_JAL: begin
                dnpc_next = pc_rel;
            end
            OP_JALR: begin
                dnpc_next = {reg_rel[31:1], 1'b0};
            end
            OP_BRANCH: begin
                // taken already carries the negate flag
                if (taken) begin
                    dnpc_next = pc_rel;
                end else begin
                    dnpc_next = snpc;
                end
            end
            default: begin
                dnpc_next = snpc;
            end
        endcase
    end

endmodule

/* testbench/exu_cases.txt */
# W addr word | R addr expected word | P addr expected word, a host read during the next X
# X class aluop src size signed negate usecode rs1 rs2 imm pc rd dnpc halted code, all hex
X 0 0 0 0 0 0 0 00000005 00000007 00000000 00000100 0000000c 00000104 0 00000000
X 0 0 0 0 0 0 0 00000010 fffffffd 00000000 00000104 0000000d 00000108 0 00000000
X 0 2 1 0 0 0 0 00000003 00000000 00000004 00000108 00000030 0000010c 0 00000000
X 0 6 0 0 0 0 0 80000000 00000004 00000000 0000010c 08000000 00000110 0 00000000
X 0 7 0 0 0 0 0 80000000 00000004 00000000 00000110 f8000000 00000114 0 00000000
X 0 3 0 0 0 0 0 ffffffff 00000001 00000000 00000114 00000001 00000118 0 00000000
X 0 4 0 0 0 0 0 ffffffff 00000001 00000000 00000118 00000000 0000011c 0 00000000
X 0 5 1 0 0 0 0 f0f0f0f0 00000000 0ff00ff0 0000011c ff00ff00 00000120 0 00000000
X 0 8 0 0 0 0 0 00ff0000 000000ff 00000000 00000120 00ff00ff 00000124 0 00000000
X 0 9 1 0 0 0 0 12345678 00000000 0000ffff 00000124 00005678 00000128 0 00000000
X 0 0 3 0 0 0 0 00000000 00000000 12345000 00000128 12345000 0000012c 0 00000000
X 0 0 2 0 0 0 0 00000000 00000000 00001000 0000012c 0000112c 00000130 0 00000000
X 3 1 0 0 0 0 0 00000005 00000005 00000020 00000200 00000001 00000220 0 00000000
X 3 1 0 0 0 1 0 00000005 00000005 00000020 00000204 00000000 00000208 0 00000000
X 3 3 0 0 0 0 0 fffffff0 00000001 fffffff0 00000300 00000001 000002f0 0 00000000
X 3 4 0 0 0 1 0 00000001 00000002 00000040 00000304 00000000 00000308 0 00000000
X 4 0 2 0 0 0 0 00000000 00000000 00000100 00000400 00000404 00000500 0 00000000
X 5 0 1 0 0 0 0 00001001 00000000 00000010 00000500 00000504 00001010 0 00000000
W 00000040 11223344
W 00000044 aabbccdd
X 2 0 1 0 0 0 0 00000040 000000ee 00000001 00000600 00000000 00000604 0 00000000
X 2 0 1 0 0 0 0 00000040 000000ff 00000003 00000604 00000000 00000608 0 00000000
X 2 0 1 1 0 0 0 00000040 00001234 00000006 00000608 00000000 0000060c 0 00000000
X 2 0 1 0 0 0 0 00000044 0000005a 00000000 0000060c 00000000 00000610 0 00000000
X 2 0 1 2 0 0 0 00000048 cafef00d 00000000 00000610 00000000 00000614 0 00000000
X 2 0 1 0 0 0 0 00000048 00000077 00000002 00000614 00000000 00000618 0 00000000
R 00000040 ff22ee44
R 00000044 1234cc5a
R 00000048 ca77f00d
X 1 0 1 0 1 0 0 00000040 00000000 00000003 00000700 ffffffff 00000704 0 00000000
X 1 0 1 0 0 0 0 00000040 00000000 00000001 00000704 000000ee 00000708 0 00000000
X 1 0 1 1 1 0 0 00000044 00000000 00000000 00000708 ffffcc5a 0000070c 0 00000000
X 1 0 1 1 0 0 0 00000044 00000000 00000000 0000070c 0000cc5a 00000710 0 00000000
X 1 0 1 1 1 0 0 00000048 00000000 00000002 00000710 ffffca77 00000714 0 00000000
P 00000040 ff22ee44
X 1 0 1 2 0 0 0 00000044 00000000 00000000 00000714 1234cc5a 00000718 0 00000000
X 6 0 0 0 0 0 0 00000055 00000000 00000000 00000800 00000055 00000804 1 00000009
X 6 0 0 0 0 0 1 0000002a 00000000 00000000 00000804 0000002a 00000808 1 0000002a

/* testbench/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_CASES    = 64;
    localparam int CASE_CYCLES  = 20;                 // budget per case line

    logic      clk;
    logic      rst_n;
    logic      op_valid;
    op_class_e op_class;
    alu_op_e   alu_op;
    alu_src_e  alu_src;
    mem_size_e mem_size;
    logic      mem_signed;
    logic      cmp_negate;
    logic      use_rs1_code;
    word_t     rs1_d;
    word_t     rs2_d;
    word_t     imm;
    word_t     pc;
    word_t     rd_d;
    word_t     dnpc;
    word_t     csrw;
    logic      done;
    logic      halted;
    word_t     halt_code;
    logic      host_req;
    logic      host_we;
    word_t     host_addr;
    word_t     host_wdata;
    word_t     host_rdata;
    logic      host_ack;

    logic [7:0] case_tag [0:MAX_CASES-1];
    word_t      case_fld [0:MAX_CASES-1][0:14];
    int         n_cases = 0;
    logic       cases_loaded = 1'b0;
    int         err_count = 0;
    logic       read_armed = 1'b0;                    // host read rides on the next op
    word_t      armed_addr;
    word_t      armed_exp;

    exu_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op_class     (op_class),
        .alu_op       (alu_op),
        .alu_src      (alu_src),
        .mem_size     (mem_size),
        .mem_signed   (mem_signed),
        .cmp_negate   (cmp_negate),
        .use_rs1_code (use_rs1_code),
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .imm          (imm),
        .pc           (pc),
        .rd_d         (rd_d),
        .dnpc         (dnpc),
        .csrw         (csrw),
        .done         (done),
        .halted       (halted),
        .halt_code    (halt_code),
        .host_req     (host_req),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_rdata   (host_rdata),
        .host_ack     (host_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                       // 20 ns period
    end

    task automatic fail_run(input string what);
        $display("%s at %0t", what, $time);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            err_count++;
            $display("CHECK FAILED time=%0t %s actual=%h expected=%h",
                     $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            err_count++;
            $display("CHECK FAILED time=%0t %s actual=%b expected=%b",
                     $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic load_cases();
        int               fd;
        int               code;
        int               nf;
        logic [7:0]       tag;
        logic [8*128-1:0] rest;
        word_t            val;
        logic             at_end;
        fd = $fopen("testbench/exu_cases.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open testbench/exu_cases.txt");
        end else begin
            at_end = 1'b0;
            while (!at_end) begin
                code = $fscanf(fd, " %c", tag);
                if (code != 1) begin
                    at_end = 1'b1;
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);              // comment line
                end else if (tag != "W" && tag != "R" && tag != "P" && tag != "X") begin
                    fail_run($sformatf("unknown tag %c in the cases file", tag));
                end else if (n_cases == MAX_CASES) begin
                    fail_run("the cases file has more lines than the testbench holds");
                end else begin
                    case_tag[n_cases] = tag;
                    nf = (tag == "X") ? 15 : 2;           // W, R, P: address and word
                    for (int k = 0; k < nf; k++) begin
                        code = $fscanf(fd, "%h", val);
                        if (code != 1) begin
                            fail_run($sformatf("case line %0d is too short", n_cases));
                        end
                        case_fld[n_cases][k] = val;
                    end
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic host_access(input logic write, input word_t addr, input word_t wdata,
                               output word_t rdata);
        @(negedge clk);
        host_req   = 1'b1;
        host_we    = write;
        host_addr  = addr;
        host_wdata = wdata;
        @(negedge clk);
        host_req = 1'b0;
        while (host_ack !== 1'b1) begin
            @(negedge clk);
        end
        rdata = host_rdata;
    endtask

    task automatic run_op(input int idx);
        word_t exp_rd;
        word_t exp_dnpc;
        word_t exp_code;
        word_t got_host;
        logic  exp_halt;
        logic  mem_op;
        logic  seen_done;
        logic  seen_ack;
        exp_rd   = case_fld[idx][11];
        exp_dnpc = case_fld[idx][12];
        exp_halt = case_fld[idx][13][0];
        exp_code = case_fld[idx][14];
        got_host = '0;
        @(negedge clk);
        op_class     = op_class_e'(case_fld[idx][0][2:0]);
        alu_op       = alu_op_e'(case_fld[idx][1][3:0]);
        alu_src      = alu_src_e'(case_fld[idx][2][1:0]);
        mem_size     = mem_size_e'(case_fld[idx][3][1:0]);
        mem_signed   = case_fld[idx][4][0];
        cmp_negate   = case_fld[idx][5][0];
        use_rs1_code = case_fld[idx][6][0];
        rs1_d        = case_fld[idx][7];
        rs2_d        = case_fld[idx][8];
        imm          = case_fld[idx][9];
        pc           = case_fld[idx][10];
        mem_op       = (op_class == OP_LOAD) || (op_class == OP_STORE);
        op_valid     = 1'b1;
        if (read_armed) begin
            host_req  = 1'b1;                         // competes with the lsu
            host_we   = 1'b0;
            host_addr = armed_addr;
        end
        @(negedge clk);
        op_valid  = 1'b0;
        host_req  = 1'b0;
        seen_done = done;
        seen_ack  = 1'b0;
        if (!mem_op && !seen_done) begin
            fail_run($sformatf("done did not follow op_valid by one cycle on case %0d", idx));
        end
        while (!seen_done || (read_armed && !seen_ack)) begin
            @(negedge clk);
            if (done) begin
                seen_done = 1'b1;
            end
            if (host_ack) begin
                seen_ack = 1'b1;
                got_host = host_rdata;
            end
        end
        check_word("rd_d", rd_d, exp_rd);
        check_word("dnpc", dnpc, exp_dnpc);
        check_word("csrw", csrw, rs2_d);              // csr write value is rs2
        check_bit("halted", halted, exp_halt);
        if (exp_halt) begin
            check_word("halt_code", halt_code, exp_code);
        end
        if (read_armed) begin
            check_word("host_rdata", got_host, armed_exp);
            read_armed = 1'b0;
        end
    endtask

    // watchdog scaled to the number of case lines
    initial begin
        wait (cases_loaded);
        repeat (n_cases * CASE_CYCLES + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired, %0d case lines did not finish in time", n_cases);
        $display("tests failed");
        $fatal(1, "simulation timed out");
    end

    initial begin
        word_t got;
        rst_n        = 1'b0;
        op_valid     = 1'b0;
        op_class     = OP_ALU;
        alu_op       = ADD;
        alu_src      = SRC_RS1_RS2;
        mem_size     = MEM_WORD;
        mem_signed   = 1'b0;
        cmp_negate   = 1'b0;
        use_rs1_code = 1'b0;
        rs1_d        = '0;
        rs2_d        = '0;
        imm          = '0;
        pc           = '0;
        host_req     = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("done", done, 1'b0);
        check_bit("host_ack", host_ack, 1'b0);
        check_bit("halted", halted, 1'b0);
        for (int i = 0; i < n_cases; i++) begin
            case (case_tag[i])
                "W": begin
                    host_access(1'b1, case_fld[i][0], case_fld[i][1], got);
                end
                "R": begin
                    host_access(1'b0, case_fld[i][0], '0, got);
                    check_word("host_rdata", got, case_fld[i][1]);
                end
                "P": begin
                    read_armed = 1'b1;
                    armed_addr = case_fld[i][0];
                    armed_exp  = case_fld[i][1];
                end
                default: begin
                    run_op(i);
                end
            endcase
        end
        if (err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
